//--- include/ifu_defines.svh
`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// ==============================
// Cache geometry
// ==============================

// Byte offset inside a 16 byte line
`define IFU_OFFSET_BITS 4

// Four lines, direct mapped
`define IFU_INDEX_BITS 2
`define IFU_LINES 4

// Remaining upper address bits
`define IFU_TAG_BITS 26

`define IFU_LINE_WORDS 4

// ==============================
// Fetch behavior
// ==============================

`define IFU_RESET_PC 32'h3000_0000

// Top address byte of the uncached SRAM window
`define IFU_SRAM_REGION 8'h0f

// Stages between fault detection and the fault output
`define IFU_FAULT_DEPTH 4

`endif

//--- source/ifu_pkg.sv
`include "ifu_defines.svh"

package ifu_pkg;

  // ==============================
  // Fetch address
  // ==============================

  typedef struct packed {
    logic [`IFU_TAG_BITS-1:0]   tag;
    logic [`IFU_INDEX_BITS-1:0] index;
    logic [1:0]                 word;     // Word within the line
    logic [1:0]                 byte_sel; // Nonzero means misaligned
  } fetch_fields_s;

  typedef union packed {
    logic [31:0]   raw;
    fetch_fields_s fields;
  } fetch_addr_u;

  // ==============================
  // Fetch FSM and cache line
  // ==============================

  typedef enum logic {
    READ_CACHE  = 1'b0,
    READ_MEMORY = 1'b1
  } fetch_state_e;

  typedef struct packed {
    logic                            valid;
    logic [`IFU_TAG_BITS-1:0]        tag;
    logic [`IFU_LINE_WORDS*32-1:0]   data;  // Word 0 in the low bits
  } cache_line_s;

endpackage

//--- source/icache_array.sv
`timescale 1ns/1ps
`include "ifu_defines.svh"

module icache_array
  import ifu_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        clear_cache,
  input  fetch_addr_u pc,
  input  logic        fill_enable,
  input  logic        beat_valid,
  input  logic [31:0] beat_data,
  output logic        hit,
  output logic [31:0] hit_word
);

  localparam int LINE_BITS = `IFU_LINE_WORDS * 32;

  cache_line_s lines [`IFU_LINES];
  cache_line_s line_sel;
  logic        is_sram;

  // ==============================
  // Lookup
  // ==============================

  assign line_sel = lines[pc.fields.index];
  assign is_sram  = pc.raw[31:24] == `IFU_SRAM_REGION;  // SRAM window bypasses the cache

  assign hit = line_sel.valid && (line_sel.tag == pc.fields.tag) && !is_sram;

  // Select one word of the indexed line
  assign hit_word = line_sel.data[{pc.fields.word, 5'd0} +: 32];

  // ==============================
  // Fill and invalidate
  // ==============================

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `IFU_LINES; i++) begin
        lines[i].valid <= 1'b0;
      end
    end else begin
      if (clear_cache) begin
        for (int i = 0; i < `IFU_LINES; i++) begin
          lines[i].valid <= 1'b0;
        end
      end

      // Beats enter at the top and move down, first beat ends in word 0
      if (fill_enable && beat_valid) begin
        lines[pc.fields.index].valid <= 1'b1;
        lines[pc.fields.index].tag   <= pc.fields.tag;
        lines[pc.fields.index].data  <= {beat_data, line_sel.data[LINE_BITS-1:32]};
      end
    end
  end

endmodule

//--- source/burst_reader.sv
`timescale 1ns/1ps
`include "ifu_defines.svh"

module burst_reader
  import ifu_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  logic        req_start,
  input  fetch_addr_u req_addr,
  input  logic        req_cached,

  output logic [31:0] araddr,
  output logic        arvalid,
  output logic [7:0]  arlen,
  input  logic        arready,

  output logic        rready,
  input  logic [31:0] rdata,
  input  logic        rvalid,
  input  logic        rlast,

  output logic        busy,
  output logic        beat_valid,
  output logic [31:0] beat_data,
  output logic        beat_last
);

  logic accept;

  assign accept = req_start && !busy;

  // ==============================
  // Beat forwarding
  // ==============================

  assign beat_valid = rvalid && rready;
  assign beat_data  = rdata;
  assign beat_last  = beat_valid && rlast;

  // ==============================
  // Address and read channel control
  // ==============================

  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid <= 1'b0;
      rready  <= 1'b0;
      busy    <= 1'b0;
    end else begin
      if (accept) begin
        arvalid <= 1'b1;
        busy    <= 1'b1;
      end
      if (arvalid && arready) begin  // Address taken, open the read channel
        arvalid <= 1'b0;
        rready  <= 1'b1;
      end
      if (beat_last) begin
        rready <= 1'b0;
        busy   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      if (req_cached) begin
        araddr <= {req_addr.fields.tag, req_addr.fields.index, {`IFU_OFFSET_BITS{1'b0}}};
        arlen  <= 8'd3;  // Whole line in four beats
      end else begin
        araddr <= req_addr.raw;
        arlen  <= 8'd0;
      end
    end
  end

endmodule

//--- source/fetch_control.sv
`timescale 1ns/1ps
`include "ifu_defines.svh"

module fetch_control
  import ifu_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  logic [31:0] npc,
  input  logic        npc_valid,
  input  logic        idu_ready,
  input  logic        block,
  input  logic        clear_pipeline,

  input  logic        hit,
  input  logic [31:0] hit_word,

  input  logic        busy,
  input  logic        beat_valid,
  input  logic [31:0] beat_data,
  input  logic        beat_last,

  output fetch_addr_u pc,
  output logic [31:0] ifu_pc,
  output logic [31:0] inst,
  output logic        inst_valid,
  output logic        req_start,
  output fetch_addr_u req_addr,
  output logic        req_cached,
  output logic        fill_enable,
  output logic        enable,
  output logic        inst_addr_misaligned
);

  fetch_state_e                state;
  logic                        pipeline_empty;
  logic                        discard;  // Redirect arrived during a burst
  logic [`IFU_FAULT_DEPTH-1:0] fault_shift;

  logic is_sram;
  logic aligned;
  logic can_fetch;
  logic may_request;
  logic miss_go;
  logic fault_set;
  logic take_hit;
  logic take_beat;

  // ==============================
  // Fetch decision
  // ==============================

  assign is_sram     = pc.raw[31:24] == `IFU_SRAM_REGION;
  assign aligned     = pc.fields.byte_sel == 2'b00;
  assign can_fetch   = (state == READ_CACHE) && !block && idu_ready;

  // Only go to memory for a pc the core really wants
  assign may_request = pipeline_empty || (npc_valid && (npc == pc.raw));
  assign miss_go     = can_fetch && !hit && may_request && !busy;

  assign take_hit  = !clear_pipeline && can_fetch && hit;
  assign take_beat = !clear_pipeline && (state == READ_MEMORY) && beat_valid
                     && is_sram && !discard;
  assign req_start = !clear_pipeline && miss_go && aligned;
  assign fault_set = !clear_pipeline && miss_go && !aligned;

  assign req_addr    = pc;
  assign req_cached  = !is_sram;
  assign fill_enable = (state == READ_MEMORY) && !is_sram && !discard;
  assign enable      = busy;

  assign inst_addr_misaligned = fault_shift[`IFU_FAULT_DEPTH-1];

  // ==============================
  // Control state
  // ==============================

  always_ff @(posedge clock) begin
    if (reset) begin
      pc.raw         <= `IFU_RESET_PC;
      state          <= READ_CACHE;
      pipeline_empty <= 1'b1;
      discard        <= 1'b0;
      inst_valid     <= 1'b0;
      fault_shift    <= '0;
    end else begin
      if (clear_pipeline) begin  // Redirect wins over any fetch
        pc.raw         <= npc;
        inst_valid     <= 1'b0;
        pipeline_empty <= 1'b1;
        fault_shift    <= '0;
      end else begin
        inst_valid <= take_hit || take_beat;  // One cycle per instruction
        if (take_hit || take_beat) begin
          pc.raw         <= pc.raw + 32'd4;
          pipeline_empty <= 1'b0;
        end
        if (!block) begin
          fault_shift <= {fault_shift[`IFU_FAULT_DEPTH-2:0], fault_shift[0] | fault_set};
        end
      end

      // A started burst always runs to its last beat
      case (state)
        READ_CACHE: begin
          if (req_start) begin
            state <= READ_MEMORY;
          end
        end
        READ_MEMORY: begin
          if (beat_last) begin
            state   <= READ_CACHE;
            discard <= 1'b0;
          end else if (clear_pipeline) begin
            discard <= 1'b1;
          end
        end
        default: state <= READ_CACHE;
      endcase
    end
  end

  // ==============================
  // Instruction output
  // ==============================

  always_ff @(posedge clock) begin
    if (take_hit) begin
      inst   <= hit_word;
      ifu_pc <= pc.raw;
    end else if (take_beat) begin
      inst   <= beat_data;  // Uncached word straight from the bus
      ifu_pc <= pc.raw;
    end else if (fault_set) begin
      ifu_pc <= pc.raw;     // Report the faulting address
    end
  end

endmodule

//--- source/ifu_top.sv
`timescale 1ns/1ps

module ifu_top
  import ifu_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  logic [31:0] npc,
  input  logic        npc_valid,
  output logic [31:0] ifu_pc,

  output logic        inst_valid,
  output logic [31:0] inst,
  input  logic        idu_ready,
  input  logic        block,

  output logic        enable,
  output logic [31:0] araddr,
  output logic        arvalid,
  output logic [7:0]  arlen,
  input  logic        arready,

  output logic        rready,
  input  logic [31:0] rdata,
  input  logic [1:0]  rresp,
  input  logic        rvalid,
  input  logic        rlast,

  output logic        inst_addr_misaligned,
  input  logic        clear_cache,
  input  logic        clear_pipeline
);

  fetch_addr_u pc;
  fetch_addr_u req_addr;
  logic        hit;
  logic [31:0] hit_word;
  logic        req_start;
  logic        req_cached;
  logic        fill_enable;
  logic        busy;
  logic        beat_valid;
  logic [31:0] beat_data;
  logic        beat_last;

  // ==============================
  // Fetch controller
  // ==============================

  fetch_control control_i (
    .clock                (clock),
    .reset                (reset),
    .npc                  (npc),
    .npc_valid            (npc_valid),
    .idu_ready            (idu_ready),
    .block                (block),
    .clear_pipeline       (clear_pipeline),
    .hit                  (hit),
    .hit_word             (hit_word),
    .busy                 (busy),
    .beat_valid           (beat_valid),
    .beat_data            (beat_data),
    .beat_last            (beat_last),
    .pc                   (pc),
    .ifu_pc               (ifu_pc),
    .inst                 (inst),
    .inst_valid           (inst_valid),
    .req_start            (req_start),
    .req_addr             (req_addr),
    .req_cached           (req_cached),
    .fill_enable          (fill_enable),
    .enable               (enable),
    .inst_addr_misaligned (inst_addr_misaligned)
  );

  // ==============================
  // Cache and memory port
  // ==============================

  icache_array cache_i (
    .clock       (clock),
    .reset       (reset),
    .clear_cache (clear_cache),
    .pc          (pc),
    .fill_enable (fill_enable),
    .beat_valid  (beat_valid),
    .beat_data   (beat_data),
    .hit         (hit),
    .hit_word    (hit_word)
  );

  // Read response code is not checked
  burst_reader reader_i (
    .clock      (clock),
    .reset      (reset),
    .req_start  (req_start),
    .req_addr   (req_addr),
    .req_cached (req_cached),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arlen      (arlen),
    .arready    (arready),
    .rready     (rready),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .rlast      (rlast),
    .busy       (busy),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_last  (beat_last)
  );

endmodule

//--- bench/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  input  logic [7:0]  arlen,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  output logic        rlast,
  input  logic        rready
);

  logic        active;
  logic [31:0] beat_addr;
  logic [7:0]  beats_left;
  logic [1:0]  wait_cycles;

  // Each word holds its own word address mixed with a fixed pattern
  assign rdata = {beat_addr[31:2], 2'b00} ^ 32'hA5A5_0000;
  assign rresp = 2'b00;
  assign rlast = rvalid && (beats_left == 8'd0);

  initial begin
    arready     = 1'b0;
    rvalid      = 1'b0;
    active      = 1'b0;
    beat_addr   = '0;
    beats_left  = '0;
    wait_cycles = '0;
  end

  always @(posedge clock) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      active  <= 1'b0;
    end else if (!active) begin
      if (arvalid && arready) begin
        arready     <= 1'b0;
        active      <= 1'b1;
        beat_addr   <= araddr;
        beats_left  <= arlen;
        wait_cycles <= 2'($urandom % 4);
      end else if (arvalid) begin
        arready <= 1'($urandom % 2);  // Random address accept delay
      end
    end else if (rvalid && rready) begin
      rvalid      <= 1'b0;
      beat_addr   <= beat_addr + 32'd4;
      beats_left  <= beats_left - 8'd1;
      wait_cycles <= 2'($urandom % 4);
      active      <= beats_left != 8'd0;
    end else if (!rvalid) begin
      if (wait_cycles == 2'd0) begin
        rvalid <= 1'b1;
      end else begin
        wait_cycles <= wait_cycles - 2'd1;  // Gap before the next beat
      end
    end
  end

endmodule

//--- bench/ifu_tb.sv
`timescale 1ns/1ps
`include "ifu_defines.svh"

module ifu_tb
  import ifu_pkg::*;
();

  localparam int CLOCK_PERIOD = 100;
  localparam int NUM_TESTS    = 7;

  typedef struct {
    string       name;
    bit          redirect;     // Pulse clear_pipeline with npc
    bit          flush;        // Pulse clear_cache with the redirect
    logic [31:0] npc;
    int          fetches;      // Instructions expected
    int          stall;        // Held-off cycles
    int          stall_start;  // First held-off cycle
    bit          stall_block;  // Stall with block, else with idu_ready
    bit          fault;
    int          requests;     // AXI address transfers expected
    int          arlen;
  } test_t;

  // ==============================
  // Stimulus table
  // ==============================

  test_t tests [NUM_TESTS] = '{
    '{"reset_fill",        1'b0, 1'b0, 32'h0000_0000, 4, 0, 1, 1'b0, 1'b0, 1, 3},
    '{"uncached_redirect", 1'b1, 1'b0, 32'h0f00_0010, 3, 0, 1, 1'b0, 1'b0, 3, 0},
    '{"stall_ready",       1'b0, 1'b0, 32'h0000_0000, 2, 6, 1, 1'b0, 1'b0, 2, 0},
    '{"stall_block",       1'b1, 1'b0, 32'h3000_0008, 2, 6, 1, 1'b1, 1'b0, 0, 0},
    '{"flush_refetch",     1'b1, 1'b1, 32'h3000_0004, 3, 0, 1, 1'b0, 1'b0, 1, 3},
    '{"misaligned",        1'b1, 1'b0, 32'h2000_0042, 0, 0, 1, 1'b1, 1'b1, 0, 0},
    '{"misaligned_block",  1'b1, 1'b0, 32'h2000_0082, 0, 3, 2, 1'b1, 1'b1, 0, 0}
  };

  logic         clock;
  logic         reset;
  logic [31:0]  npc;
  logic         npc_valid;
  logic         idu_ready;
  logic         block;
  logic         clear_cache;
  logic         clear_pipeline;
  logic [31:0]  inst;
  logic         inst_valid;
  logic [31:0]  ifu_pc;
  logic         enable;
  logic         inst_addr_misaligned;
  logic [31:0]  araddr;
  logic         arvalid;
  logic [7:0]   arlen;
  logic         arready;
  logic         rready;
  logic [31:0]  rdata;
  logic [1:0]   rresp;
  logic         rvalid;
  logic         rlast;

  int           errors;
  int           checks;
  int           req_count;
  logic [31:0]  ar_addr_q [$];
  logic [7:0]   ar_len_q [$];
  logic [31:0]  next_pc;  // Expected pc of the next instruction
  logic         read_open;
  fetch_state_e fsm_state;

  ifu_top dut_i (.*);

  axi_mem_model memory_i (.*);

  assign fsm_state = dut_i.control_i.state;

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  always @(posedge clock) begin
    if (!reset && arvalid && arready) begin  // Log every address transfer
      req_count++;
      ar_addr_q.push_back(araddr);
      ar_len_q.push_back(arlen);
    end
  end

  // A read stays open from its address phase to the edge after its last beat
  always @(posedge clock) begin
    if (reset) begin
      read_open <= 1'b0;
    end else if (rvalid && rready && rlast) begin
      read_open <= 1'b0;
    end else if (arvalid) begin
      read_open <= 1'b1;
    end
  end

  // ==============================
  // Compare tasks
  // ==============================

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // ==============================
  // One table entry
  // ==============================

  task automatic run_test(input int t);
    string       name;
    logic [31:0] start_pc;
    logic [31:0] held_inst;
    logic [31:0] held_pc;
    logic [31:0] exp_addr;
    int          base_req;
    int          cycle;
    int          got;
    bit          fault_seen;
    bit          stalled;
    name      = tests[t].name;
    base_req  = req_count;
    held_inst = inst;
    held_pc   = ifu_pc;
    ar_addr_q.delete();
    ar_len_q.delete();
    if (tests[t].redirect) begin
      @(posedge clock);
      clear_pipeline <= 1'b1;
      clear_cache    <= tests[t].flush;
      npc            <= tests[t].npc;
      next_pc = tests[t].npc;
    end
    start_pc   = next_pc;
    cycle      = 0;
    got        = 0;
    fault_seen = 1'b0;
    while ((got < tests[t].fetches) || (tests[t].fault && !fault_seen)) begin
      @(posedge clock);
      cycle++;
      stalled = (cycle >= tests[t].stall_start) &&
                (cycle < tests[t].stall_start + tests[t].stall);
      clear_pipeline <= 1'b0;
      clear_cache    <= 1'b0;
      npc            <= next_pc;  // Core asks for the pc it expects
      npc_valid      <= 1'b1;
      idu_ready      <= !(stalled && !tests[t].stall_block);
      block          <= stalled && tests[t].stall_block;
      @(negedge clock);
      check_bit({name, " enable"}, arvalid || read_open, enable);
      if (!tests[t].fault && (cycle < tests[t].stall_start + tests[t].stall + 1)) begin
        check_bit({name, " held inst_valid"}, 1'b0, inst_valid);
        check_word({name, " held inst"}, held_inst, inst);
        check_word({name, " held ifu_pc"}, held_pc, ifu_pc);
        check_count({name, " held requests"}, base_req, req_count);
      end else if (inst_valid) begin
        check_word({name, " inst"}, next_pc ^ 32'hA5A5_0000, inst);
        check_word({name, " ifu_pc"}, next_pc, ifu_pc);
        next_pc = next_pc + 32'd4;
        got++;
      end
      if (tests[t].fault && inst_addr_misaligned && !fault_seen) begin
        fault_seen = 1'b1;
        check_count({name, " fault delay"}, `IFU_FAULT_DEPTH + tests[t].stall, cycle - 1);
        check_word({name, " fault ifu_pc"}, start_pc, ifu_pc);
      end
    end
    if (!tests[t].fault) begin
      check_bit({name, " fault"}, 1'b0, inst_addr_misaligned);
    end
    check_count({name, " requests"}, tests[t].requests, req_count - base_req);
    for (int r = 0; r < ar_addr_q.size(); r++) begin
      if (tests[t].arlen == 3) begin
        exp_addr = start_pc & 32'hFFFF_FFF0;  // Line aligned burst
      end else begin
        exp_addr = start_pc + 32'(4 * r);
      end
      check_word({name, " araddr"}, exp_addr, ar_addr_q[r]);
      check_count({name, " arlen"}, tests[t].arlen, int'(ar_len_q[r]));
    end
  endtask

  // ==============================
  // Main sequence and watchdog
  // ==============================

  initial begin
    void'($urandom(81));
    reset          = 1'b1;
    npc            = '0;
    npc_valid      = 1'b0;
    idu_ready      = 1'b1;
    block          = 1'b0;
    clear_cache    = 1'b0;
    clear_pipeline = 1'b0;
    next_pc        = `IFU_RESET_PC;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * 200 * CLOCK_PERIOD);
    $display("Watchdog: the tests did not finish within %0d cycles, fetch FSM in %s",
             NUM_TESTS * 200, fsm_state.name());
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- src.f
+incdir+include
source/ifu_pkg.sv
source/icache_array.sv
source/burst_reader.sv
source/fetch_control.sv
source/ifu_top.sv
bench/axi_mem_model.sv
bench/ifu_tb.sv
